/* source/cmdrsp_pkg.sv */
`default_nettype none

package cmdrsp_pkg;

    // ======================================
    // Bus and engine widths
    // ======================================
    localparam int ADDR_WIDTH = 12;
    localparam int DATA_WIDTH = 32;
    localparam int NUM_CHAN   = 8;
    localparam int CHAN_W     = 3;
    localparam int LEN_W      = 16;
    localparam int PERF_DEPTH = 16;
    localparam int PERF_CNT_W = 16;
    localparam int PERF_PTR_W = $clog2(PERF_DEPTH);

    // Decode spans: kick block below 0x040, profiler below 0x100
    localparam int KICK_SPAN_W = 6;
    localparam int PERF_SPAN_W = 8;

    // ======================================
    // Address map
    // ======================================
    // Profiler registers, compared on the low byte only
    localparam logic [7:0] PERF_CONFIG_ADDR    = 8'h40;
    localparam logic [7:0] PERF_DATA_LOW_ADDR  = 8'h44;
    localparam logic [7:0] PERF_DATA_HIGH_ADDR = 8'h48;
    localparam logic [7:0] PERF_STATUS_ADDR    = 8'h4C;

    // Configuration block, full address compare
    localparam logic [ADDR_WIDTH-1:0] CFG_CHAN_EN_ADDR = 12'h100;
    localparam logic [ADDR_WIDTH-1:0] CFG_SCRATCH_ADDR = 12'h104;
    localparam logic [ADDR_WIDTH-1:0] CFG_ID_ADDR      = 12'h108;

    localparam logic [DATA_WIDTH-1:0] CFG_ID_VALUE  = 32'hC0DE_0100;
    localparam logic [DATA_WIDTH-1:0] PERF_BAD_DATA = 32'hDEAD_BEEF;

    // ======================================
    // Profiler events
    // ======================================
    typedef enum logic {
        EVT_KICK = 1'b0,
        EVT_DONE = 1'b1
    } perf_event_e;

    typedef struct packed {
        logic              valid;
        perf_event_e       evt_type;
        logic [CHAN_W-1:0] chan;
    } perf_event_t;

endpackage

`default_nettype wire

/* source/cmdrsp_if.sv */
`default_nettype none

interface cmdrsp_if;
    import cmdrsp_pkg::*;

    // Command channel
    logic                  cmd_valid;
    logic                  cmd_ready;
    logic                  cmd_pwrite;
    logic [ADDR_WIDTH-1:0] cmd_paddr;
    logic [DATA_WIDTH-1:0] cmd_pwdata;

    // Response channel
    logic                  rsp_valid;
    logic                  rsp_ready;
    logic [DATA_WIDTH-1:0] rsp_prdata;
    logic                  rsp_pslverr;

    // Requester side
    modport master (
        output cmd_valid, cmd_pwrite, cmd_paddr, cmd_pwdata, rsp_ready,
        input  cmd_ready, rsp_valid, rsp_prdata, rsp_pslverr
    );

    // Target side
    modport slave (
        input  cmd_valid, cmd_pwrite, cmd_paddr, cmd_pwdata, rsp_ready,
        output cmd_ready, rsp_valid, rsp_prdata, rsp_pslverr
    );

endinterface

`default_nettype wire

/* source/perf_if.sv */
`default_nettype none

interface perf_if;
    import cmdrsp_pkg::*;

    // Profiler control from the router
    logic                  cfg_enable;
    logic                  cfg_mode;
    logic                  cfg_clear;
    logic                  fifo_rd;

    // Queue head and status from the FIFO
    logic [DATA_WIDTH-1:0] data_low;
    logic [DATA_WIDTH-1:0] data_high;
    logic                  empty;
    logic                  full;
    logic [PERF_CNT_W-1:0] count;

    // Register side in the router
    modport regs (
        output cfg_enable, cfg_mode, cfg_clear, fifo_rd,
        input  data_low, data_high, empty, full, count
    );

    modport fifo (
        input  cfg_enable, cfg_mode, cfg_clear, fifo_rd,
        output data_low, data_high, empty, full, count
    );

endinterface

`default_nettype wire

/* source/cmdrsp_router.sv */
`default_nettype none

module cmdrsp_router (
    input  logic     clk,
    input  logic     rst_n,
    cmdrsp_if.slave  s,
    cmdrsp_if.master m0,
    cmdrsp_if.master m1,
    perf_if.regs     perf
);
    import cmdrsp_pkg::*;

    logic                  hit_kick;
    logic                  hit_perf;
    logic                  cmd_acc;
    logic                  perf_acc;
    logic                  pending;
    logic                  sel_kick;
    logic                  sel_perf;
    logic                  perf_rsp_valid;
    logic [DATA_WIDTH-1:0] perf_rsp_data;
    logic [DATA_WIDTH-1:0] perf_rd_data;
    logic [7:0]            perf_addr;

    // ======================================
    // Address decode
    // ======================================
    // Kick block at 0x000-0x03F, profiler at 0x040-0x0FF, config otherwise
    assign hit_kick  = (s.cmd_paddr[ADDR_WIDTH-1:KICK_SPAN_W] == '0);
    assign hit_perf  = (s.cmd_paddr[ADDR_WIDTH-1:PERF_SPAN_W] == '0) && !hit_kick;
    assign perf_addr = s.cmd_paddr[7:0];

    // Only one command in flight
    assign s.cmd_ready = !pending && (hit_kick ? m0.cmd_ready :
                                      hit_perf ? 1'b1 : m1.cmd_ready);
    assign cmd_acc  = s.cmd_valid && s.cmd_ready;
    assign perf_acc = cmd_acc && hit_perf;

    // Remember the target until its response is taken
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pending  <= 1'b0;
            sel_kick <= 1'b0;
            sel_perf <= 1'b0;
        end else begin
            if (cmd_acc) begin
                pending  <= 1'b1;
                sel_kick <= hit_kick;
                sel_perf <= hit_perf;
            end else if (s.rsp_valid && s.rsp_ready) begin
                pending <= 1'b0;
            end
        end
    end

    // ======================================
    // Command and response steering
    // ======================================
    assign m0.cmd_valid  = s.cmd_valid && hit_kick && !pending;
    assign m0.cmd_pwrite = s.cmd_pwrite;
    assign m0.cmd_paddr  = s.cmd_paddr;
    assign m0.cmd_pwdata = s.cmd_pwdata;

    // Default route
    assign m1.cmd_valid  = s.cmd_valid && !hit_kick && !hit_perf && !pending;
    assign m1.cmd_pwrite = s.cmd_pwrite;
    assign m1.cmd_paddr  = s.cmd_paddr;
    assign m1.cmd_pwdata = s.cmd_pwdata;

    assign m0.rsp_ready = sel_kick && s.rsp_ready;
    assign m1.rsp_ready = !sel_kick && !sel_perf && s.rsp_ready;

    assign s.rsp_valid   = sel_kick ? m0.rsp_valid :
                           sel_perf ? perf_rsp_valid : m1.rsp_valid;
    assign s.rsp_prdata  = sel_kick ? m0.rsp_prdata :
                           sel_perf ? perf_rsp_data : m1.rsp_prdata;
    // Profiler space never errors
    assign s.rsp_pslverr = sel_kick ? m0.rsp_pslverr :
                           sel_perf ? 1'b0 : m1.rsp_pslverr;

    // ======================================
    // Profiler registers
    // ======================================
    // Clear bit drops by itself one cycle after the write
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            perf.cfg_enable <= 1'b0;
            perf.cfg_mode   <= 1'b0;
            perf.cfg_clear  <= 1'b0;
        end else if (perf_acc && s.cmd_pwrite && perf_addr == PERF_CONFIG_ADDR) begin
            perf.cfg_enable <= s.cmd_pwdata[0];
            perf.cfg_mode   <= s.cmd_pwdata[1];
            perf.cfg_clear  <= s.cmd_pwdata[2];
        end else begin
            perf.cfg_clear <= 1'b0;
        end
    end

    // Pop on the accept of a DATA_LOW read, head is sampled in the same cycle
    assign perf.fifo_rd = perf_acc && !s.cmd_pwrite && perf_addr == PERF_DATA_LOW_ADDR;

    always_comb begin
        case (perf_addr)
            PERF_CONFIG_ADDR:    perf_rd_data = {29'h0, 1'b0, perf.cfg_mode, perf.cfg_enable};
            PERF_DATA_LOW_ADDR:  perf_rd_data = perf.data_low;
            PERF_DATA_HIGH_ADDR: perf_rd_data = perf.data_high;
            PERF_STATUS_ADDR:    perf_rd_data = {perf.count, 14'h0, perf.full, perf.empty};
            default:             perf_rd_data = PERF_BAD_DATA;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            perf_rsp_valid <= 1'b0;
        end else if (perf_acc) begin
            perf_rsp_valid <= 1'b1;
        end else if (sel_perf && s.rsp_ready) begin
            perf_rsp_valid <= 1'b0;
        end
    end

    // Writes answer with zero data
    always_ff @(posedge clk) begin
        if (perf_acc) begin
            perf_rsp_data <= s.cmd_pwrite ? '0 : perf_rd_data;
        end
    end

endmodule

`default_nettype wire

/* source/descr_kick.sv */
`default_nettype none

module descr_kick (
    input  logic                              clk,
    input  logic                              rst_n,
    cmdrsp_if.slave                           bus,
    input  logic [cmdrsp_pkg::NUM_CHAN-1:0]   chan_en,
    output logic [cmdrsp_pkg::NUM_CHAN-1:0]   chan_busy,
    output cmdrsp_pkg::perf_event_t           event_out
);
    import cmdrsp_pkg::*;

    logic [LEN_W-1:0]  cnt [NUM_CHAN];
    logic [CHAN_W-1:0] sel_chan;
    logic [CHAN_W-1:0] done_chan;
    logic              addr_ok;
    logic              cmd_acc;
    logic              done_hit;
    logic              kick_ok;

    // Channel register at 4 * channel, upper half of the window unused
    assign sel_chan = bus.cmd_paddr[CHAN_W+1:2];
    assign addr_ok  = (bus.cmd_paddr[KICK_SPAN_W-1:CHAN_W+2] == '0);

    assign bus.cmd_ready = !bus.rsp_valid;
    assign cmd_acc       = bus.cmd_valid && bus.cmd_ready;

    // Channel about to hit zero, lowest index reported when several finish
    always_comb begin
        done_hit  = 1'b0;
        done_chan = '0;
        for (int i = NUM_CHAN - 1; i >= 0; i--) begin
            if (cnt[i] == LEN_W'(1)) begin
                done_hit  = 1'b1;
                done_chan = CHAN_W'(i);
            end
        end
    end

    // Idle, enabled, nonzero length, and no done event competing
    assign kick_ok = cmd_acc && bus.cmd_pwrite && addr_ok && chan_en[sel_chan] &&
                     cnt[sel_chan] == '0 && bus.cmd_pwdata[LEN_W-1:0] != '0 && !done_hit;

    // Countdown, one step per cycle
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < NUM_CHAN; i++) begin
                cnt[i] <= '0;
            end
        end else begin
            for (int i = 0; i < NUM_CHAN; i++) begin
                if (kick_ok && sel_chan == CHAN_W'(i)) begin
                    cnt[i] <= bus.cmd_pwdata[LEN_W-1:0];
                end else if (cnt[i] != '0) begin
                    cnt[i] <= cnt[i] - 1'b1;
                end
            end
        end
    end

    always_comb begin
        for (int i = 0; i < NUM_CHAN; i++) begin
            chan_busy[i] = (cnt[i] != '0);
        end
    end

    // One event per cycle, done wins
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            event_out <= '0;
        end else begin
            event_out.valid    <= done_hit || kick_ok;
            event_out.evt_type <= done_hit ? EVT_DONE : EVT_KICK;
            event_out.chan     <= done_hit ? done_chan : sel_chan;
        end
    end

    // ======================================
    // Response
    // ======================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            bus.rsp_valid <= 1'b0;
        end else if (cmd_acc) begin
            bus.rsp_valid <= 1'b1;
        end else if (bus.rsp_ready) begin
            bus.rsp_valid <= 1'b0;
        end
    end

    // Reads return the remaining count
    always_ff @(posedge clk) begin
        if (cmd_acc) begin
            bus.rsp_pslverr <= bus.cmd_pwrite ? !kick_ok : !addr_ok;
            bus.rsp_prdata  <= (!bus.cmd_pwrite && addr_ok) ?
                               DATA_WIDTH'(cnt[sel_chan]) : '0;
        end
    end

endmodule

`default_nettype wire

/* source/cfg_regs.sv */
`default_nettype none

module cfg_regs (
    input  logic                            clk,
    input  logic                            rst_n,
    cmdrsp_if.slave                         bus,
    output logic [cmdrsp_pkg::NUM_CHAN-1:0] chan_en
);
    import cmdrsp_pkg::*;

    logic                  cmd_acc;
    logic                  wr_acc;
    logic                  rd_err;
    logic [DATA_WIDTH-1:0] rd_data;
    logic [DATA_WIDTH-1:0] scratch;

    // Single response slot
    assign bus.cmd_ready = !bus.rsp_valid;
    assign cmd_acc       = bus.cmd_valid && bus.cmd_ready;
    assign wr_acc        = cmd_acc && bus.cmd_pwrite;

    // Decode and error check on the full address
    always_comb begin
        rd_data = '0;
        rd_err  = 1'b0;
        case (bus.cmd_paddr)
            CFG_CHAN_EN_ADDR: rd_data = DATA_WIDTH'(chan_en);
            CFG_SCRATCH_ADDR: rd_data = scratch;
            CFG_ID_ADDR: begin
                rd_data = CFG_ID_VALUE;
                // ID is read only
                rd_err  = bus.cmd_pwrite;
            end
            default: rd_err = 1'b1;
        endcase
    end

    // Channel enable mask
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            chan_en <= '0;
        end else if (wr_acc && bus.cmd_paddr == CFG_CHAN_EN_ADDR) begin
            chan_en <= bus.cmd_pwdata[NUM_CHAN-1:0];
        end
    end

    always_ff @(posedge clk) begin
        if (wr_acc && bus.cmd_paddr == CFG_SCRATCH_ADDR) begin
            scratch <= bus.cmd_pwdata;
        end
    end

    // ======================================
    // Response
    // ======================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            bus.rsp_valid <= 1'b0;
        end else if (cmd_acc) begin
            bus.rsp_valid <= 1'b1;
        end else if (bus.rsp_ready) begin
            bus.rsp_valid <= 1'b0;
        end
    end

    // Zero data on writes and on errors
    always_ff @(posedge clk) begin
        if (cmd_acc) begin
            bus.rsp_pslverr <= rd_err;
            bus.rsp_prdata  <= (bus.cmd_pwrite || rd_err) ? '0 : rd_data;
        end
    end

endmodule

`default_nettype wire

/* source/perf_fifo.sv */
`default_nettype none

module perf_fifo (
    input  logic                    clk,
    input  logic                    rst_n,
    perf_if.fifo                    perf,
    input  cmdrsp_pkg::perf_event_t event_in
);
    import cmdrsp_pkg::*;

    logic [DATA_WIDTH-1:0] ts;
    logic [DATA_WIDTH-1:0] last_ts;
    logic [DATA_WIDTH-1:0] stamp;
    logic [DATA_WIDTH-1:0] mem_ts [PERF_DEPTH];
    logic [CHAN_W:0]       mem_evt [PERF_DEPTH];
    logic [PERF_PTR_W-1:0] wr_ptr;
    logic [PERF_PTR_W-1:0] rd_ptr;
    logic [PERF_CNT_W-1:0] count;
    logic                  push;
    logic                  pop;

    // Clear wins over both push and pop, a full FIFO drops the event
    assign push  = perf.cfg_enable && event_in.valid && !perf.full && !perf.cfg_clear;
    assign pop   = perf.fifo_rd && !perf.empty && !perf.cfg_clear;
    // Mode 1 stores the gap since the previous stored event
    assign stamp = perf.cfg_mode ? ts - last_ts : ts;

    // ======================================
    // Timestamp and pointers
    // ======================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ts      <= '0;
            last_ts <= '0;
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            count   <= '0;
        end else begin
            ts <= ts + 1'b1;
            if (perf.cfg_clear) begin
                wr_ptr <= '0;
                rd_ptr <= '0;
                count  <= '0;
            end else begin
                if (push) begin
                    wr_ptr  <= wr_ptr + 1'b1;
                    last_ts <= ts;
                end
                if (pop) begin
                    rd_ptr <= rd_ptr + 1'b1;
                end
                if (push && !pop) begin
                    count <= count + 1'b1;
                end else if (pop && !push) begin
                    count <= count - 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            mem_ts[wr_ptr]  <= stamp;
            mem_evt[wr_ptr] <= {event_in.evt_type, event_in.chan};
        end
    end

    // Head of queue, type in bit 3 and channel below
    assign perf.data_low  = mem_ts[rd_ptr];
    assign perf.data_high = {{(DATA_WIDTH-CHAN_W-1){1'b0}}, mem_evt[rd_ptr]};
    assign perf.count     = count;
    assign perf.empty     = (count == '0);
    assign perf.full      = (count == PERF_CNT_W'(PERF_DEPTH));

endmodule

`default_nettype wire

/* source/cmdrsp_top.sv */
`default_nettype none

module cmdrsp_top (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic                              s_cmd_valid,
    output logic                              s_cmd_ready,
    input  logic                              s_cmd_pwrite,
    input  logic [cmdrsp_pkg::ADDR_WIDTH-1:0] s_cmd_paddr,
    input  logic [cmdrsp_pkg::DATA_WIDTH-1:0] s_cmd_pwdata,
    output logic                              s_rsp_valid,
    input  logic                              s_rsp_ready,
    output logic [cmdrsp_pkg::DATA_WIDTH-1:0] s_rsp_prdata,
    output logic                              s_rsp_pslverr,
    output logic [cmdrsp_pkg::NUM_CHAN-1:0]   chan_busy
);
    import cmdrsp_pkg::*;

    cmdrsp_if s_bus ();
    cmdrsp_if kick_bus ();
    cmdrsp_if cfg_bus ();
    perf_if   perf_bus ();

    logic [NUM_CHAN-1:0] chan_en;
    perf_event_t         kick_evt;

    // Plain slave port onto the router side bus
    assign s_bus.cmd_valid  = s_cmd_valid;
    assign s_bus.cmd_pwrite = s_cmd_pwrite;
    assign s_bus.cmd_paddr  = s_cmd_paddr;
    assign s_bus.cmd_pwdata = s_cmd_pwdata;
    assign s_bus.rsp_ready  = s_rsp_ready;
    assign s_cmd_ready      = s_bus.cmd_ready;
    assign s_rsp_valid      = s_bus.rsp_valid;
    assign s_rsp_prdata     = s_bus.rsp_prdata;
    assign s_rsp_pslverr    = s_bus.rsp_pslverr;

    cmdrsp_router u_router (
        .clk   (clk),
        .rst_n (rst_n),
        .s     (s_bus.slave),
        .m0    (kick_bus.master),
        .m1    (cfg_bus.master),
        .perf  (perf_bus.regs)
    );

    descr_kick u_kick (
        .clk       (clk),
        .rst_n     (rst_n),
        .bus       (kick_bus.slave),
        .chan_en   (chan_en),
        .chan_busy (chan_busy),
        .event_out (kick_evt)
    );

    cfg_regs u_cfg (
        .clk     (clk),
        .rst_n   (rst_n),
        .bus     (cfg_bus.slave),
        .chan_en (chan_en)
    );

    perf_fifo u_perf (
        .clk      (clk),
        .rst_n    (rst_n),
        .perf     (perf_bus.fifo),
        .event_in (kick_evt)
    );

endmodule

`default_nettype wire

/* dv/tb_cmdrsp_top.sv */
`default_nettype none

module tb_cmdrsp_top;
    timeunit 1ns;
    timeprecision 100ps;
    import cmdrsp_pkg::*;

    localparam int MAX_REC    = 64;
    localparam int CLK_PERIOD = 20;

    logic                  clk;
    logic                  rst_n;
    logic                  s_cmd_valid;
    logic                  s_cmd_ready;
    logic                  s_cmd_pwrite;
    logic [ADDR_WIDTH-1:0] s_cmd_paddr;
    logic [DATA_WIDTH-1:0] s_cmd_pwdata;
    logic                  s_rsp_valid;
    logic                  s_rsp_ready;
    logic [DATA_WIDTH-1:0] s_rsp_prdata;
    logic                  s_rsp_pslverr;
    logic [NUM_CHAN-1:0]   chan_busy;

    // One record table entry per line of the data file
    logic [7:0]  rec_op   [MAX_REC];
    logic [31:0] rec_addr [MAX_REC];
    logic [31:0] rec_data [MAX_REC];
    logic [31:0] rec_exp  [MAX_REC];
    logic [31:0] rec_mask [MAX_REC];
    logic [31:0] rec_err  [MAX_REC];
    int          num_rec;
    int          idle_sum;
    int          checks;
    int          errors;
    integer      seed;
    logic        loaded;

    always #(CLK_PERIOD / 2) clk = ~clk;

    cmdrsp_top uut (
        .clk           (clk),
        .rst_n         (rst_n),
        .s_cmd_valid   (s_cmd_valid),
        .s_cmd_ready   (s_cmd_ready),
        .s_cmd_pwrite  (s_cmd_pwrite),
        .s_cmd_paddr   (s_cmd_paddr),
        .s_cmd_pwdata  (s_cmd_pwdata),
        .s_rsp_valid   (s_rsp_valid),
        .s_rsp_ready   (s_rsp_ready),
        .s_rsp_prdata  (s_rsp_prdata),
        .s_rsp_pslverr (s_rsp_pslverr),
        .chan_busy     (chan_busy)
    );

    // ========================================
    // Record loading and checks
    // ========================================
    task automatic load_records();
        int          fd;
        int          n;
        string       line;
        logic [7:0]  op;
        logic [31:0] addr;
        logic [31:0] data;
        logic [31:0] exp;
        logic [31:0] mask;
        logic [31:0] err;
        fd = $fopen("dv/cmdrsp_input.txt", "r");
        if (fd == 0) begin
            $display("Could not open the stimulus file dv/cmdrsp_input.txt");
        end else begin
            while (!$feof(fd) && num_rec < MAX_REC) begin
                n = $fgets(line, fd);
                // Skip blank and comment lines
                if (n > 0 && line.len() > 1 && line[0] != "#") begin
                    n = $sscanf(line, "%c %h %h %h %h %h", op, addr, data, exp, mask, err);
                    if (n == 6) begin
                        rec_op[num_rec]   = op;
                        rec_addr[num_rec] = addr;
                        rec_data[num_rec] = data;
                        rec_exp[num_rec]  = exp;
                        rec_mask[num_rec] = mask;
                        rec_err[num_rec]  = err;
                        if (op == "i") begin
                            idle_sum += int'(data);
                        end
                        num_rec++;
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    // Masked compare of one response or status value
    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp, input logic [31:0] mask);
        checks++;
        assert ((got & mask) == (exp & mask)) else begin
            $display("Fail t=%0t %s expected %h got %h", $time, name, exp & mask, got & mask);
            errors++;
        end
    endtask

    // One command and its response with a random 0 to 3 cycle stall on rsp_ready
    task automatic send_cmd(input int idx);
        int          delay;
        logic [31:0] first_data;
        logic        first_err;
        delay        = $random(seed) & 3;
        s_cmd_valid  = 1'b1;
        s_cmd_pwrite = (rec_op[idx] == "w");
        s_cmd_paddr  = rec_addr[idx][ADDR_WIDTH-1:0];
        s_cmd_pwdata = rec_data[idx];
        // Ready seen mid cycle means acceptance on the next rising edge
        @(negedge clk);
        while (!s_cmd_ready) @(negedge clk);
        @(posedge clk);
        #1;
        s_cmd_valid = 1'b0;
        s_rsp_ready = (delay == 0);
        @(negedge clk);
        checks++;
        assert (s_rsp_valid) else begin
            $display("Fail t=%0t no response one cycle after command acceptance", $time);
            errors++;
        end
        first_data = s_rsp_prdata;
        first_err  = s_rsp_pslverr;
        repeat (delay) begin
            @(posedge clk);
            #1;
        end
        s_rsp_ready = 1'b1;
        if (delay > 0) begin
            @(negedge clk);
        end
        // Response in the handshake cycle must still be the one first seen
        checks++;
        assert (s_rsp_valid && s_rsp_prdata == first_data && s_rsp_pslverr == first_err)
        else begin
            $display("Fail t=%0t response dropped or changed while rsp_ready was low", $time);
            errors++;
        end
        // Command side stays blocked until the response is taken
        check_value("s_cmd_ready", 32'(s_cmd_ready), 32'h0, 32'h1);
        check_value("s_rsp_prdata", s_rsp_prdata, rec_exp[idx], rec_mask[idx]);
        check_value("s_rsp_pslverr", 32'(s_rsp_pslverr), rec_err[idx], 32'h1);
        @(posedge clk);
        #1;
        s_rsp_ready = 1'b0;
    endtask

    // Idle cycles and then chan_busy against the record
    task automatic idle_wait(input int idx);
        repeat (rec_data[idx]) @(posedge clk);
        @(negedge clk);
        check_value("chan_busy", 32'(chan_busy), rec_exp[idx], rec_mask[idx]);
        @(posedge clk);
        #1;
    endtask

    // ========================================
    // Main sequence
    // ========================================
    initial begin
        int err_before;
        clk          = 1'b0;
        rst_n        = 1'b0;
        s_cmd_valid  = 1'b0;
        s_cmd_pwrite = 1'b0;
        s_cmd_paddr  = '0;
        s_cmd_pwdata = '0;
        s_rsp_ready  = 1'b0;
        seed         = 32'h3b5c_bf85;
        num_rec      = 0;
        idle_sum     = 0;
        checks       = 0;
        errors       = 0;
        loaded       = 1'b0;
        load_records();
        repeat (3) @(posedge clk);
        #1;
        rst_n = 1'b1;
        if (num_rec == 0) begin
            $display("No stimulus records were loaded");
        end else begin
            loaded = 1'b1;
            for (int i = 0; i < num_rec; i++) begin
                err_before = errors;
                if (rec_op[i] == "i") begin
                    idle_wait(i);
                end else begin
                    send_cmd(i);
                end
                $display("record %0d %c %h: %s", i, rec_op[i], rec_addr[i][ADDR_WIDTH-1:0],
                         (errors == err_before) ? "ok" : "mismatch");
            end
        end
        $display("records %0d, checks %0d, errors %0d", num_rec, checks, errors);
        if (errors == 0 && num_rec > 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

    // Budget of ten clock periods per record and per idle cycle
    initial begin
        wait (loaded === 1'b1);
        #((num_rec + idle_sum) * 10 * CLK_PERIOD);
        $display("Watchdog expired before all records finished");
        $display(">>> FAIL");
        $finish;
    end

endmodule

`default_nettype wire

/* dv/cmdrsp_input.txt */
# op addr wdata_or_idle expected mask err, all fields hex
# op w write, r read, i idle cycles then chan_busy compared under mask
w 104 A5A51234 00000000 00000000 0
r 104 00000000 A5A51234 FFFFFFFF 0
r 108 00000000 C0DE0100 FFFFFFFF 0
r 200 00000000 00000000 FFFFFFFF 1
w 008 00000005 00000000 00000000 1
w 040 00000001 00000000 00000000 0
w 100 00000004 00000000 00000000 0
w 008 00000005 00000000 00000000 0
i 000 00000000 00000004 00000004 0
i 000 0000000A 00000000 000000FF 0
r 04C 00000000 00020000 FFFFFFFF 0
r 048 00000000 00000002 FFFFFFFF 0
r 044 00000000 00000000 00000000 0
r 048 00000000 0000000A FFFFFFFF 0
w 040 00000007 00000000 00000000 0
r 04C 00000000 00000001 FFFFFFFF 0
r 040 00000000 00000003 FFFFFFFF 0
w 008 00000005 00000000 00000000 0
i 000 0000000A 00000000 000000FF 0
r 044 00000000 00000000 00000000 0
r 044 00000000 00000005 FFFFFFFF 0
r 0F0 00000000 DEADBEEF FFFFFFFF 0

/* cmdrsp.f */
source/cmdrsp_pkg.sv
source/cmdrsp_if.sv
source/perf_if.sv
source/cmdrsp_router.sv
source/descr_kick.sv
source/cfg_regs.sv
source/perf_fifo.sv
source/cmdrsp_top.sv
dv/tb_cmdrsp_top.sv

/* Makefile */
VERILATOR  ?= verilator
TOP        := tb_cmdrsp_top
RTL_TOP    := cmdrsp_top
FILELIST   := cmdrsp.f
OBJ_DIR    := obj_dir
LOG        := sim.log
LINT_FLAGS := --lint-only --timing
SIM_FLAGS  := --binary --timing --assert -j 0

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

sim:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -qx '>>> PASS' $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
